/* list.f */
+incdir+source
source/nstep_pkg.sv
source/level_sync.sv
source/nstep_trigger.sv
source/nstep_cnt.sv
source/nstep_ctl_top.sv
verif/tb_clk_gen.sv
verif/nstep_tb.sv

/* source/level_sync.sv */
/*
 * Two-flop synchronizer for asynchronous level inputs.
 * Each bit is resynchronized on its own; do not use for buses.
 */
`timescale 1ns/1ns
`include "nstep_defs.svh"

module level_sync #(
   parameter int W = 1
) (
   input  logic         clk,
   input  logic         rst,
   input  logic [W-1:0] d,
   output logic [W-1:0] q
);

   // first stage may go metastable, only q is used downstream
   logic [W-1:0] meta;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         meta <= '0;
         q    <= '0;
      end
      else
      begin
         meta <= d;
         q    <= meta;
      end
   end

endmodule

/* source/nstep_cnt.sv */
/*
 * Step counter of one clock domain. Takes its count on a load pulse,
 * then raises the enable for exactly that many cycles after start.
 */
`timescale 1ns/1ns
`include "nstep_defs.svh"

module nstep_cnt (
   input  logic                     clk,
   input  logic                     rst,
   input  nstep_pkg::nstep_pulse_t  pulse,
   input  logic [`NSTEP_CNT_W-1:0]  count,
   input  logic                     domain_hit,
   input  logic                     test_mode,
   input  logic                     force_cken,
   output logic                     sel
);

   // count as loaded from the debug port
   logic [`NSTEP_CNT_W-1:0] init_cnt;

   // working count of the current burst
   logic [`NSTEP_CNT_W-1:0] work_cnt;
   logic [`NSTEP_CNT_W-1:0] work_cnt_nxt;

   // registered enable, before test gating
   logic en;
   logic en_nxt;

   // decoded count values
   logic init_one;
   logic init_all;
   logic work_gt1;

   // ------------------------------------------------------------------
   // initial count
   // ------------------------------------------------------------------

   // count and domain_hit come straight off the debug port, the
   // synchronizer delay on the load pulse gives them time to settle
   always_ff @(posedge clk)
   begin
      if (rst)
         init_cnt <= '0;
      else if (pulse.load && domain_hit)
         init_cnt <= count;
   end

   assign init_one = (init_cnt == `NSTEP_CNT_W'(1));
   assign init_all = &init_cnt;
   assign work_gt1 = (work_cnt > `NSTEP_CNT_W'(1));

   // ------------------------------------------------------------------
   // working count and enable
   // ------------------------------------------------------------------

   // count down only while the domain clock really runs
   always_comb
   begin
      if (pulse.start)
         work_cnt_nxt = init_cnt;
      else if (sel && (init_cnt != '0))
         work_cnt_nxt = work_cnt - `NSTEP_CNT_W'(1);
      else
         work_cnt_nxt = work_cnt;
   end

   // a single step has no count above one, so it needs the delayed start
   // all ones keeps the domain running with no count at all
   assign en_nxt = (init_one & pulse.start_dly)
                 | work_gt1
                 | init_all;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         work_cnt <= '0;
         en       <= 1'b0;
      end
      else
      begin
         work_cnt <= work_cnt_nxt;
         en       <= en_nxt;
      end
   end

   // test mode and forced enable own the clock switch
   assign sel = en & ~test_mode & ~force_cken;

   // ------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------

   // debug port word must not move while it is being captured
   a_cmd_hold: assert property (
      @(posedge clk) disable iff (rst)
      pulse.load |-> ($stable(count) && $stable(domain_hit))
                     ##1 ($stable(count) && $stable(domain_hit))
   ) else $error("count or domain changed within the load window");

   a_cnt_enables: assert property (
      @(posedge clk) disable iff (rst)
      work_gt1 |=> en
   ) else $error("working count above one without an enable");

endmodule

/* source/nstep_ctl_top.sv */
/*
 * Top of the n-step clock-enable controller. One trigger block feeds
 * a step counter for each clock domain; nstep_sel goes to the switch.
 */
`timescale 1ns/1ns
`include "nstep_defs.svh"

module nstep_ctl_top (
   input  logic                     clk,
   input  logic                     rst,
   input  nstep_pkg::nstep_cmd_t    cmd,
   input  logic                     cmd_vld,
   input  logic                     capture,
   input  logic                     start_clk,
   input  logic                     test_mode,
   input  logic                     force_cken,
   input  logic [`NSTEP_LCM_W-1:0]  div_mult,
   output nstep_pkg::nstep_sel_t    nstep_sel
);

   // shared one-shots, every domain sees the same start
   nstep_pkg::nstep_pulse_t pulse;

   // ------------------------------------------------------------------
   // trigger and lcm phase
   // ------------------------------------------------------------------

   nstep_trigger u_trigger (
      .clk       (clk),
      .rst       (rst),
      .cmd_vld   (cmd_vld),
      .capture   (capture),
      .start_clk (start_clk),
      .div_mult  (div_mult),
      .pulse     (pulse)
   );

   // ------------------------------------------------------------------
   // one step counter per domain
   // ------------------------------------------------------------------

   // count is common, the mask bit picks which domains take it
   for (genvar i = 0; i < `NSTEP_DOMAINS; i++)
   begin : g_dom
      nstep_cnt u_cnt (
         .clk        (clk),
         .rst        (rst),
         .pulse      (pulse),
         .count      (cmd.count),
         .domain_hit (cmd.domain[i]),
         .test_mode  (test_mode),
         .force_cken (force_cken),
         .sel        (nstep_sel[i])
      );
   end

endmodule

/* source/nstep_defs.svh */
/*
 * Build parameters for the n-step clock-enable controller.
 * Include this before the package and in every RTL file.
 */
`ifndef NSTEP_DEFS_SVH
`define NSTEP_DEFS_SVH

// width of one step count, all ones means run continually
`define NSTEP_CNT_W 4

// width of the divider lcm value and of its down-counter
`define NSTEP_LCM_W 14

// number of clock domains served by the controller
`define NSTEP_DOMAINS 2

// lcm counter value that raises the coincident edge one cycle later
`define NSTEP_COIN_TAP 3

`endif

/* source/nstep_pkg.sv */
/*
 * Shared types of the n-step controller.
 * The debug load word, the trigger one-shots and the enable vector.
 */
`include "nstep_defs.svh"

package nstep_pkg;

   // ------------------------------------------------------------------
   // debug port load word
   // ------------------------------------------------------------------

   // step count plus the mask of domains that take it
   typedef struct packed {
      logic [`NSTEP_CNT_W-1:0]   count;
      logic [`NSTEP_DOMAINS-1:0] domain;
   } nstep_cmd_t;

   // ------------------------------------------------------------------
   // one-shots from the trigger block to every counter
   // ------------------------------------------------------------------

   typedef struct packed {
      logic load;       // a command was just accepted
      logic start;      // burst begins on this cycle
      logic start_dly;  // start, one cycle later
   } nstep_pulse_t;

   // one enable bit per clock domain
   typedef logic [`NSTEP_DOMAINS-1:0] nstep_sel_t;

endpackage

/* source/nstep_trigger.sv */
/*
 * Trigger block of the n-step controller. Brings in the debug load and
 * capture levels, runs the lcm coincident-edge counter, and sends the
 * load, start and delayed start one-shots to all domain counters.
 */
`timescale 1ns/1ns
`include "nstep_defs.svh"

module nstep_trigger (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     cmd_vld,
   input  logic                     capture,
   input  logic                     start_clk,
   input  logic [`NSTEP_LCM_W-1:0]  div_mult,
   output nstep_pkg::nstep_pulse_t  pulse
);

   // synchronized debug levels
   logic vld_sync;
   logic capture_sync;

   // edge history for the load one-shot
   logic vld_sync_dly;

   // lcm divider counter and coincident edge
   logic [`NSTEP_LCM_W-1:0] lcm_cnt;
   logic [`NSTEP_LCM_W-1:0] lcm_cnt_nxt;
   logic                    coin_edge;

   // start register and its delay line
   logic start_q;
   logic start_dly;
   logic start_dly1;

   // ------------------------------------------------------------------
   // synchronizers, debug clock levels into clk
   // ------------------------------------------------------------------

   level_sync #(
      .W (1)
   ) u_vld_sync (
      .clk (clk),
      .rst (rst),
      .d   (cmd_vld),
      .q   (vld_sync)
   );

   level_sync #(
      .W (1)
   ) u_capture_sync (
      .clk (clk),
      .rst (rst),
      .d   (capture),
      .q   (capture_sync)
   );

   // ------------------------------------------------------------------
   // lcm counter, marks the repeatable coincident edge
   // ------------------------------------------------------------------

   // reload whenever the clocks are held off, or at the end of a period
   // period is div_mult cycles as long as div_mult is 2 or more
   always_comb
   begin
      if (!start_clk)
         lcm_cnt_nxt = div_mult;
      else if (lcm_cnt > `NSTEP_LCM_W'(1))
         lcm_cnt_nxt = lcm_cnt - `NSTEP_LCM_W'(1);
      else
         lcm_cnt_nxt = div_mult;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         lcm_cnt   <= '0;
         coin_edge <= 1'b0;
      end
      else
      begin
         lcm_cnt   <= lcm_cnt_nxt;
         // one cycle after the tap value
         coin_edge <= (lcm_cnt == `NSTEP_LCM_W'(`NSTEP_COIN_TAP));
      end
   end

   // ------------------------------------------------------------------
   // load and start one-shots
   // ------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         vld_sync_dly <= 1'b0;
         start_q      <= 1'b0;
         start_dly    <= 1'b0;
         start_dly1   <= 1'b0;
      end
      else
      begin
         vld_sync_dly <= vld_sync;
         // capture only counts on a coincident edge
         if (coin_edge)
            start_q <= capture_sync;
         start_dly    <= start_q;
         start_dly1   <= start_dly;
      end
   end

   // rising edges of the registered levels
   always_comb
   begin
      pulse.load      = vld_sync & ~vld_sync_dly;
      pulse.start     = start_q & ~start_dly;
      pulse.start_dly = start_dly & ~start_dly1;
   end

   // ------------------------------------------------------------------
   // checks
   // ------------------------------------------------------------------

   // burst always lines up with the lcm phase
   a_start_on_coin: assert property (
      @(posedge clk) disable iff (rst)
      $rose(pulse.start) |-> $past(coin_edge)
   ) else $error("start rose away from a coincident edge");

   a_load_one_shot: assert property (
      @(posedge clk) disable iff (rst)
      pulse.load |=> !pulse.load
   ) else $error("load pulse wider than one cycle");

   a_start_one_shot: assert property (
      @(posedge clk) disable iff (rst)
      pulse.start |=> !pulse.start
   ) else $error("start pulse wider than one cycle");

endmodule

/* verif/nstep_tb.sv */
/*
 * Directed testbench for the n-step clock-enable controller.
 * Loads step counts over the debug port, fires capture and counts
 * the enable cycles of every domain against the burst rules.
 */
`timescale 1ns/1ns
`include "nstep_defs.svh"

module nstep_tb;

   // worst case cost of one burst is the window, capture release, delay and drain
   localparam int MAX_DIV      = 40;
   localparam int BURST_BUDGET = (2 * MAX_DIV + 40) + (MAX_DIV + 10) + 8 + MAX_DIV + 30;
   localparam int NUM_BURSTS   = 13;
   localparam int TIMEOUT      = NUM_BURSTS * BURST_BUDGET + 200;

   logic                    clk;
   logic                    rst;
   nstep_pkg::nstep_cmd_t   cmd;
   logic                    cmd_vld;
   logic                    capture;
   logic                    start_clk;
   logic                    test_mode;
   logic                    force_cken;
   logic [`NSTEP_LCM_W-1:0] div_mult;
   nstep_pkg::nstep_sel_t   nstep_sel;

   integer seed = 32'h7ad86303;
   int     cycle = 0;
   int     errors = 0;
   int     checks = 0;
   int     cur_div = 4;

   // results of the last burst window, one entry per domain
   int highs [`NSTEP_DOMAINS];
   int rises [`NSTEP_DOMAINS];
   int first_rise [`NSTEP_DOMAINS];

   tb_clk_gen u_clk_gen (
      .clk (clk),
      .rst (rst)
   );

   nstep_ctl_top dut (
      .clk        (clk),
      .rst        (rst),
      .cmd        (cmd),
      .cmd_vld    (cmd_vld),
      .capture    (capture),
      .start_clk  (start_clk),
      .test_mode  (test_mode),
      .force_cken (force_cken),
      .div_mult   (div_mult),
      .nstep_sel  (nstep_sel)
   );

   // free running cycle count, also the watchdog time base
   always @(posedge clk)
      cycle <= cycle + 1;

   initial
   begin
      wait (cycle >= TIMEOUT);
      $display("timeout: tests did not complete within %0d cycles", TIMEOUT);
      $display("TESTBENCH FAILED");
      $finish;
   end

   // ------------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------------

   task automatic check_sel(input string name, input nstep_pkg::nstep_sel_t got,
                            input nstep_pkg::nstep_sel_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error: %s got %h expected %h at cycle %0d", name, got, exp, cycle);
      end
   endtask

   task automatic check_count(input string name, input logic [`NSTEP_CNT_W-1:0] got,
                              input logic [`NSTEP_CNT_W-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error: %s got %h expected %h", name, got, exp);
      end
   endtask

   // two first rises must sit a whole number of lcm periods apart
   task automatic check_spacing(input string name, input int first, input int next);
      checks++;
      if (first < 0 || next < 0)
      begin
         errors++;
         $display("%s: no rise of nstep_sel[0] seen in a burst window", name);
      end
      else if ((next - first) % cur_div != 0)
      begin
         errors++;
         $display("Error: %s got %h expected a multiple of %h", name, next - first, cur_div);
      end
   endtask

   // ------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------

   function automatic int pick_value(input int lo, input int hi);
      return lo + ($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   // saturate so an overlong burst cannot wrap into a matching value
   function automatic logic [`NSTEP_CNT_W-1:0] to_count(input int n);
      if (n > (1 << `NSTEP_CNT_W) - 1)
         return '1;
      return n[`NSTEP_CNT_W-1:0];
   endfunction

   // cmd stays put after cmd_vld drops, until the next load
   task automatic load_cmd(input int count, input nstep_pkg::nstep_sel_t mask);
      nstep_pkg::nstep_cmd_t c;
      c.count  = count[`NSTEP_CNT_W-1:0];
      c.domain = mask;
      @(posedge clk);
      cmd     <= c;
      cmd_vld <= 1'b1;
      repeat (4) @(posedge clk);
      cmd_vld <= 1'b0;
      repeat (3) @(posedge clk);
   endtask

   // hold start_clk low so the lcm counter picks up the new divider
   task automatic set_div(input int d);
      @(posedge clk);
      start_clk <= 1'b0;
      div_mult  <= d[`NSTEP_LCM_W-1:0];
      repeat (3) @(posedge clk);
      start_clk <= 1'b1;
      cur_div = d;
      @(posedge clk);
   endtask

   // raise capture, sample every domain at negedge over the window
   task automatic run_burst();
      int window;
      nstep_pkg::nstep_sel_t prev;
      window = 2 * cur_div + 40;
      prev = '0;
      for (int d = 0; d < `NSTEP_DOMAINS; d++)
      begin
         highs[d] = 0;
         rises[d] = 0;
         first_rise[d] = -1;
      end
      @(posedge clk);
      capture <= 1'b1;
      repeat (window)
      begin
         @(negedge clk);
         for (int d = 0; d < `NSTEP_DOMAINS; d++)
         begin
            if (nstep_sel[d])
            begin
               highs[d]++;
               if (!prev[d])
               begin
                  rises[d]++;
                  if (first_rise[d] < 0)
                     first_rise[d] = cycle;
               end
            end
         end
         prev = nstep_sel;
      end
      // capture low must be seen on a coincident edge before the next burst
      @(posedge clk);
      capture <= 1'b0;
      repeat (cur_div + 10) @(posedge clk);
   endtask

   // one contiguous run of exp cycles per domain, none for zero
   task automatic expect_burst(input int exp0, input int exp1);
      int exp [`NSTEP_DOMAINS];
      exp[0] = exp0;
      exp[1] = exp1;
      for (int d = 0; d < `NSTEP_DOMAINS; d++)
      begin
         check_count($sformatf("high cycles nstep_sel[%0d]", d), to_count(highs[d]),
                     to_count(exp[d]));
         check_count($sformatf("bursts nstep_sel[%0d]", d), to_count(rises[d]),
                     to_count(exp[d] != 0));
      end
   endtask

   // ------------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------------

   task automatic test_reset_idle();
      repeat (20)
      begin
         @(negedge clk);
         check_sel("nstep_sel idle", nstep_sel, '0);
      end
   endtask

   task automatic test_single_domain();
      int n;
      set_div(pick_value(4, MAX_DIV));
      repeat (4)
      begin
         n = pick_value(1, 14);
         load_cmd(n, 2'b01);
         run_burst();
         expect_burst(n, 0);
      end
   endtask

   task automatic test_both_domains();
      int n;
      int m;
      n = pick_value(1, 14);
      m = pick_value(1, 14);
      if (m == n)
         m = (n % 14) + 1;
      load_cmd(n, 2'b11);
      run_burst();
      expect_burst(n, n);
      // domain 0 keeps its old count
      load_cmd(m, 2'b10);
      run_burst();
      expect_burst(n, m);
   endtask

   task automatic test_limits();
      int window;
      window = 2 * cur_div + 40;
      load_cmd(0, 2'b10);
      load_cmd(15, 2'b01);
      @(posedge clk);
      capture <= 1'b1;
      repeat (window)
      begin
         @(negedge clk);
         check_sel("nstep_sel count 15 and 0", nstep_sel, 2'b01);
      end
      @(posedge clk);
      capture <= 1'b0;
      repeat (cur_div + 10) @(posedge clk);
      // a finite count lets the wrapped working count run out
      load_cmd(1, 2'b01);
      repeat (30) @(posedge clk);
      @(negedge clk);
      check_sel("nstep_sel after count 15", nstep_sel, '0);
   endtask

   task automatic test_phase();
      int n;
      int base;
      set_div(pick_value(4, MAX_DIV));
      n = pick_value(1, 14);
      load_cmd(n, 2'b01);
      run_burst();
      expect_burst(n, 0);
      base = first_rise[0];
      repeat (2)
      begin
         repeat (pick_value(0, cur_div - 1)) @(posedge clk);
         run_burst();
         expect_burst(n, 0);
         check_spacing("first rise spacing", base, first_rise[0]);
      end
   endtask

   task automatic test_gating();
      int n;
      n = pick_value(1, 14);
      load_cmd(n, 2'b11);
      @(posedge clk);
      test_mode <= 1'b1;
      run_burst();
      expect_burst(0, 0);
      // held count drains once the gate opens
      test_mode <= 1'b0;
      repeat (30) @(posedge clk);
      force_cken <= 1'b1;
      run_burst();
      expect_burst(0, 0);
      force_cken <= 1'b0;
      repeat (30) @(posedge clk);
      run_burst();
      expect_burst(n, n);
   endtask

   initial
   begin
      cmd        = '0;
      cmd_vld    = 1'b0;
      capture    = 1'b0;
      start_clk  = 1'b1;
      test_mode  = 1'b0;
      force_cken = 1'b0;
      div_mult   = `NSTEP_LCM_W'(4);
      @(posedge clk);
      while (rst)
         @(posedge clk);
      test_reset_idle();
      test_single_domain();
      test_both_domains();
      test_limits();
      test_phase();
      test_gating();
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

/* verif/tb_clk_gen.sv */
/*
 * Clock and reset source for the n-step controller testbench.
 * 10 ns clk, rst held high for the first 8 rising edges.
 */
`timescale 1ns/1ns

module tb_clk_gen (
   output logic clk,
   output logic rst
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // release on a rising edge like any other driven input
   initial
   begin
      rst = 1'b1;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
   end

endmodule
